//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    // address split: tag | index | word | byte
    localparam int INDEX_WIDTH    = 7;
    localparam int OFFSET_WIDTH   = 5;
    localparam int TAG_WIDTH      = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int WORDS_PER_LINE = 1 << (OFFSET_WIDTH - 2);
    localparam int WORD_SEL_WIDTH = OFFSET_WIDTH - 2;  // word number inside a line
    localparam int SET_NUM        = 1 << INDEX_WIDTH;
    localparam int WAY_NUM        = 4;                 // tree plru below is four-way only

    typedef enum logic [1:0] {
        LOOKUP    = 2'd0,
        MISS_ADDR = 2'd1,  // address phase on the refill bus
        MISS_DATA = 2'd2,  // beats arriving
        DONE      = 2'd3   // hand over the saved word
    } ctrl_state_e;

    typedef enum logic [1:0] {
        OP_NONE            = 2'd0,
        OP_INDEX_INVALID   = 2'd1,
        OP_INDEX_STORE_TAG = 2'd2,
        OP_HIT_INVALID     = 2'd3  // clears the whole set
    } cache_op_e;

    // one refill beat, broadcast to all ways
    typedef struct packed {
        logic [WAY_NUM-1:0]        way_mask;
        logic [INDEX_WIDTH-1:0]    index;
        logic [TAG_WIDTH-1:0]      tag;
        logic [WORD_SEL_WIDTH-1:0] word_num;
        logic [31:0]               word;
        logic                      set_valid;  // last beat of the line
    } way_fill_t;

    typedef struct packed {
        logic                   en;
        logic                   all_ways;
        logic [1:0]             way;
        logic [INDEX_WIDTH-1:0] index;
    } way_inv_t;

    // per-way lookup result
    typedef struct packed {
        logic        hit;
        logic [31:0] word;
    } way_look_t;

endpackage

`default_nettype wire

//--- icache_way.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way #(
    parameter int WAY_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  icache_pkg::way_fill_t fill,
    input  icache_pkg::way_inv_t  inv,
    input  logic [31:0]           fetch_addr,
    output icache_pkg::way_look_t look
);

    localparam int IDX_LO = icache_pkg::OFFSET_WIDTH;
    localparam int IDX_HI = icache_pkg::OFFSET_WIDTH + icache_pkg::INDEX_WIDTH - 1;
    localparam int TAG_LO = IDX_HI + 1;

    // storage
    logic [icache_pkg::TAG_WIDTH-1:0] tag_mem [icache_pkg::SET_NUM];
    logic [31:0] data_mem [icache_pkg::SET_NUM][icache_pkg::WORDS_PER_LINE];
    logic [icache_pkg::SET_NUM-1:0]   valid_bits;

    logic                                  fill_sel;
    logic                                  inv_sel;
    logic [icache_pkg::INDEX_WIDTH-1:0]    look_index;
    logic [icache_pkg::TAG_WIDTH-1:0]      look_tag;
    logic [icache_pkg::WORD_SEL_WIDTH-1:0] look_word;

    assign fill_sel = fill.way_mask[WAY_ID];  // ctrl already gates the mask per beat
    assign inv_sel  = inv.en && (inv.all_ways || inv.way == 2'(WAY_ID));

    // data beats land one word at a time
    always_ff @(posedge clk) begin
        if (fill_sel) begin
            data_mem[fill.index][fill.word_num] <= fill.word;
        end
    end

    // tag written together with the valid bit on the last beat
    always_ff @(posedge clk) begin
        if (fill_sel && fill.set_valid) begin
            tag_mem[fill.index] <= fill.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (inv_sel) begin
            valid_bits[inv.index] <= 1'b0;  // maintenance wins over a fill
        end else if (fill_sel && fill.set_valid) begin
            valid_bits[fill.index] <= 1'b1;
        end
    end

    // asynchronous read, resolves in the fetch cycle
    assign look_index = fetch_addr[IDX_HI:IDX_LO];
    assign look_tag   = fetch_addr[31:TAG_LO];
    assign look_word  = fetch_addr[IDX_LO-1:2];

    always_comb begin
        look.hit  = valid_bits[look_index] && (tag_mem[look_index] == look_tag);
        look.word = data_mem[look_index][look_word];
    end

endmodule

`default_nettype wire

//--- icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_en,
    input  logic                          no_cache,
    input  logic [31:0]                   fetch_addr,
    input  icache_pkg::cache_op_e         cache_op,
    input  logic [31:0]                   cache_op_addr,
    input  logic                          any_hit,
    input  logic [31:0]                   hit_word,
    input  logic [icache_pkg::WAY_NUM-1:0] victim_mask,
    output logic                          stall,
    output logic [31:0]                   inst_rdata,
    output logic                          lru_touch,
    output icache_pkg::way_fill_t         fill,
    output icache_pkg::way_inv_t          inv,
    output logic [31:0]                   araddr,
    output logic [3:0]                    arlen,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [31:0]                   rdata,
    input  logic                          rvalid,
    input  logic                          rlast,
    output logic                          rready
);

    localparam int IDX_LO = icache_pkg::OFFSET_WIDTH;
    localparam int IDX_HI = icache_pkg::OFFSET_WIDTH + icache_pkg::INDEX_WIDTH - 1;
    localparam int TAG_LO = IDX_HI + 1;

    icache_pkg::ctrl_state_e state;
    icache_pkg::ctrl_state_e state_next;

    logic [icache_pkg::WORD_SEL_WIDTH-1:0] cnt;        // beat number in the burst
    logic [icache_pkg::WORD_SEL_WIDTH-1:0] req_word;
    logic [icache_pkg::WAY_NUM-1:0]        victim_q;
    logic [31:0]                           saved_word;
    logic                                  need_mem;
    logic                                  beat;
    logic                                  last_beat;
    logic                                  cached_beat;

    assign req_word  = fetch_addr[IDX_LO-1:2];
    assign need_mem  = fetch_en && (no_cache || !any_hit);
    assign beat      = (state == icache_pkg::MISS_DATA) && rvalid;
    assign last_beat = beat && rlast;
    assign cached_beat = beat && !no_cache;

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::LOOKUP: begin
                if (need_mem) begin
                    state_next = icache_pkg::MISS_ADDR;
                end
            end
            icache_pkg::MISS_ADDR: begin
                if (arready) begin
                    state_next = icache_pkg::MISS_DATA;
                end
            end
            icache_pkg::MISS_DATA: begin
                if (last_beat) begin
                    state_next = icache_pkg::DONE;
                end
            end
            icache_pkg::DONE: state_next = icache_pkg::LOOKUP;
            default: state_next = icache_pkg::LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (state == icache_pkg::MISS_ADDR) begin
            cnt <= '0;
        end else if (beat) begin
            cnt <= cnt + 1'b1;
        end
    end

    // victim picked once, lru is frozen during the miss anyway
    always_ff @(posedge clk) begin
        if (state == icache_pkg::LOOKUP && need_mem) begin
            victim_q <= victim_mask;
        end
    end

    // requested word, or the only beat of an uncached read
    always_ff @(posedge clk) begin
        if (beat && (no_cache || cnt == req_word)) begin
            saved_word <= rdata;
        end
    end

    always_comb begin
        case (state)
            icache_pkg::LOOKUP:    stall = need_mem;
            icache_pkg::MISS_ADDR: stall = 1'b1;
            icache_pkg::MISS_DATA: stall = 1'b1;
            default:               stall = 1'b0;
        endcase
    end

    assign inst_rdata = (state == icache_pkg::DONE) ? saved_word : hit_word;
    assign lru_touch  = (state == icache_pkg::LOOKUP && fetch_en && !no_cache && any_hit)
                      || (last_beat && !no_cache);

    // refill bus
    assign araddr  = no_cache ? fetch_addr : {fetch_addr[31:IDX_LO], {IDX_LO{1'b0}}};
    assign arlen   = no_cache ? 4'd0 : 4'(icache_pkg::WORDS_PER_LINE - 1);
    assign arvalid = (state == icache_pkg::MISS_ADDR);
    assign rready  = (state == icache_pkg::MISS_DATA);

    always_comb begin
        fill.way_mask  = victim_q & {icache_pkg::WAY_NUM{cached_beat}};
        fill.index     = fetch_addr[IDX_HI:IDX_LO];
        fill.tag       = fetch_addr[31:TAG_LO];
        fill.word_num  = cnt;
        fill.word      = rdata;
        fill.set_valid = last_beat && !no_cache;
    end

    // maintenance decode, store tag only invalidates
    always_comb begin
        inv.en       = 1'b0;
        inv.all_ways = 1'b0;
        inv.way      = cache_op_addr[1:0];
        inv.index    = cache_op_addr[IDX_HI:IDX_LO];
        case (cache_op)
            icache_pkg::OP_INDEX_INVALID:   inv.en = 1'b1;
            icache_pkg::OP_INDEX_STORE_TAG: inv.en = 1'b1;
            icache_pkg::OP_HIT_INVALID: begin
                inv.en       = 1'b1;
                inv.all_ways = 1'b1;  // whole set, no tag check
            end
            default: inv.en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- icache_select.sv
`timescale 1ns/1ps
`default_nettype none

module icache_select (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [31:0]                                 fetch_addr,
    input  logic                                        lru_touch,
    input  logic                                        fill_done,
    input  logic [icache_pkg::WAY_NUM-1:0]              fill_way,
    input  icache_pkg::way_look_t [icache_pkg::WAY_NUM-1:0] look,
    output logic                                        any_hit,
    output logic [31:0]                                 hit_word,
    output logic [icache_pkg::WAY_NUM-1:0]              victim_mask
);

    localparam int IDX_LO = icache_pkg::OFFSET_WIDTH;
    localparam int IDX_HI = icache_pkg::OFFSET_WIDTH + icache_pkg::INDEX_WIDTH - 1;

    // three tree bits per set: b0 picks the half, b1/b2 the way inside it
    logic [icache_pkg::SET_NUM-1:0][2:0]  lru_bits;
    logic [icache_pkg::WAY_NUM-1:0]       hit_vec;
    logic [1:0]                           hit_way;
    logic [1:0]                           touch_way;
    logic [1:0]                           victim_way;
    logic [2:0]                           cur_bits;
    logic [icache_pkg::INDEX_WIDTH-1:0]   set_index;

    function automatic logic [1:0] onehot_idx(input logic [icache_pkg::WAY_NUM-1:0] vec);
        logic [1:0] idx;
        idx = 2'd0;
        for (int i = 0; i < icache_pkg::WAY_NUM; i++) begin
            if (vec[i]) begin
                idx = 2'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < icache_pkg::WAY_NUM; i++) begin
            hit_vec[i] = look[i].hit;
        end
    end

    assign hit_way  = onehot_idx(hit_vec);
    assign any_hit  = |hit_vec;
    assign hit_word = look[hit_way].word;

    assign set_index = fetch_addr[IDX_HI:IDX_LO];
    assign cur_bits  = lru_bits[set_index];

    assign victim_way  = {cur_bits[0], cur_bits[0] ? cur_bits[2] : cur_bits[1]};
    assign victim_mask = icache_pkg::WAY_NUM'(1) << victim_way;

    // refill end names the filled way, otherwise the hit way
    assign touch_way = fill_done ? onehot_idx(fill_way) : hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (lru_touch) begin
            lru_bits[set_index][0] <= ~touch_way[1];
            if (!touch_way[1]) begin
                lru_bits[set_index][1] <= ~touch_way[0];
            end else begin
                lru_bits[set_index][2] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_en,
    input  logic [31:0]           fetch_addr,
    input  logic                  no_cache,
    output logic [31:0]           inst_rdata,
    output logic                  stall,
    input  icache_pkg::cache_op_e cache_op,
    input  logic [31:0]           cache_op_addr,
    output logic [31:0]           araddr,
    output logic [3:0]            arlen,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [31:0]           rdata,
    input  logic                  rvalid,
    input  logic                  rlast,
    output logic                  rready
);

    icache_pkg::way_fill_t                          fill;
    icache_pkg::way_inv_t                           inv;
    icache_pkg::way_look_t [icache_pkg::WAY_NUM-1:0] look;

    logic                           any_hit;
    logic [31:0]                    hit_word;
    logic [icache_pkg::WAY_NUM-1:0] victim_mask;
    logic                           lru_touch;

    icache_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .fetch_en      (fetch_en),
        .no_cache      (no_cache),
        .fetch_addr    (fetch_addr),
        .cache_op      (cache_op),
        .cache_op_addr (cache_op_addr),
        .any_hit       (any_hit),
        .hit_word      (hit_word),
        .victim_mask   (victim_mask),
        .stall         (stall),
        .inst_rdata    (inst_rdata),
        .lru_touch     (lru_touch),
        .fill          (fill),
        .inv           (inv),
        .araddr        (araddr),
        .arlen         (arlen),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rvalid        (rvalid),
        .rlast         (rlast),
        .rready        (rready)
    );

    // each way decodes its own mask bit and way number
    for (genvar g = 0; g < icache_pkg::WAY_NUM; g++) begin : gen_way
        icache_way #(
            .WAY_ID (g)
        ) i_way (
            .clk        (clk),
            .rst        (rst),
            .fill       (fill),
            .inv        (inv),
            .fetch_addr (fetch_addr),
            .look       (look[g])
        );
    end

    icache_select i_select (
        .clk         (clk),
        .rst         (rst),
        .fetch_addr  (fetch_addr),
        .lru_touch   (lru_touch),
        .fill_done   (fill.set_valid),
        .fill_way    (fill.way_mask),
        .look        (look),
        .any_hit     (any_hit),
        .hit_word    (hit_word),
        .victim_mask (victim_mask)
    );

endmodule

`default_nettype wire

//--- tb_icache_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_mem (
    input  logic        clk,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic        rlast,
    input  logic        rready
);

    localparam logic [31:0] DATA_KEY = 32'hc0de_0000;

    logic [31:0] lcg_state = 32'hec1e_5728;
    logic [31:0] burst_addr;
    logic [3:0]  burst_len;

    // 0 to 3 wait cycles, taken from the top bits of the lcg
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:30]);
    endfunction

    // outputs change on the falling edge only
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            if (arvalid === 1'b1) begin
                repeat (next_delay()) @(negedge clk);
                arready = 1'b1;
                @(posedge clk);  // arvalid is held, so this edge takes the address
                burst_addr = araddr;
                burst_len  = arlen;
                @(negedge clk);
                arready = 1'b0;
                for (int b = 0; b <= int'(burst_len); b++) begin
                    repeat (next_delay()) @(negedge clk);
                    rdata  = (burst_addr + 32'(4 * b)) ^ DATA_KEY;
                    rvalid = 1'b1;
                    rlast  = (b == int'(burst_len));
                    do begin
                        @(posedge clk);
                    end while (rready !== 1'b1);
                    @(negedge clk);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int          CLK_PERIOD       = 40;
    localparam int          RESET_CYCLES     = 2;
    localparam int          CYCLES_PER_ENTRY = 60;
    localparam logic [31:0] DATA_KEY         = 32'hc0de_0000;

    typedef struct packed {
        icache_pkg::cache_op_e op;  // OP_NONE means a fetch
        logic [31:0]           addr;
        logic                  no_cache;
        logic                  burst;
    } entry_t;

    logic                  clk;
    logic                  rst;
    logic                  fetch_en;
    logic [31:0]           fetch_addr;
    logic                  no_cache;
    logic [31:0]           inst_rdata;
    logic                  stall;
    icache_pkg::cache_op_e cache_op;
    logic [31:0]           cache_op_addr;
    logic [31:0]           araddr;
    logic [3:0]            arlen;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    logic                  rvalid;
    logic                  rlast;
    logic                  rready;

    entry_t      table_q [$];
    int          burst_count = 0;
    int          expected_bursts = 0;
    logic        predicted;
    logic [31:0] last_araddr;
    logic [3:0]  last_arlen;

    // reference model of tags, valid bits and tree bits
    logic [icache_pkg::TAG_WIDTH-1:0] ref_tag   [icache_pkg::SET_NUM][4];
    logic                             ref_valid [icache_pkg::SET_NUM][4];
    logic [2:0]                       ref_lru   [icache_pkg::SET_NUM];

    icache_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .fetch_en      (fetch_en),
        .fetch_addr    (fetch_addr),
        .no_cache      (no_cache),
        .inst_rdata    (inst_rdata),
        .stall         (stall),
        .cache_op      (cache_op),
        .cache_op_addr (cache_op_addr),
        .araddr        (araddr),
        .arlen         (arlen),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rvalid        (rvalid),
        .rlast         (rlast),
        .rready        (rready)
    );

    tb_icache_mem i_mem (
        .clk     (clk),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bus monitor counts every address handshake
    always @(posedge clk) begin
        if (arvalid === 1'b1 && arready === 1'b1) begin
            burst_count <= burst_count + 1;
            last_araddr <= araddr;
            last_arlen  <= arlen;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic add_fetch(input logic [31:0] addr, input logic nc, input logic burst);
        entry_t e;
        e.op       = icache_pkg::OP_NONE;
        e.addr     = addr;
        e.no_cache = nc;
        e.burst    = burst;
        table_q.push_back(e);
    endtask

    task automatic add_op(input icache_pkg::cache_op_e op, input logic [31:0] addr);
        entry_t e;
        e.op       = op;
        e.addr     = addr;
        e.no_cache = 1'b0;
        e.burst    = 1'b0;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // cold line followed by hits inside it
        add_fetch(32'h0000_1044, 1'b0, 1'b1);
        add_fetch(32'h0000_1040, 1'b0, 1'b0);
        add_fetch(32'h0000_105c, 1'b0, 1'b0);
        add_fetch(32'h0000_1048, 1'b0, 1'b0);
        // five tags into set 5 so the fifth evicts the first
        for (int t = 1; t <= 5; t++) begin
            add_fetch((32'(t) << 16) | 32'h0000_00a0 | (32'(t) << 2), 1'b0, 1'b1);
        end
        add_fetch(32'h0002_00a8, 1'b0, 1'b0);
        add_fetch(32'h0003_00ac, 1'b0, 1'b0);
        add_fetch(32'h0004_00b0, 1'b0, 1'b0);
        add_fetch(32'h0001_00bc, 1'b0, 1'b1);
        // uncached reads never allocate
        add_fetch(32'h0000_2088, 1'b1, 1'b1);
        add_fetch(32'h0000_2088, 1'b1, 1'b1);
        add_fetch(32'h0000_2080, 1'b0, 1'b1);
        add_fetch(32'h0000_2088, 1'b0, 1'b0);
        add_fetch(32'h0000_1044, 1'b1, 1'b1);
        // set 9 for the maintenance ops
        for (int t = 6; t <= 9; t++) begin
            add_fetch((32'(t) << 16) | 32'h0000_0120, 1'b0, 1'b1);
        end
        add_op(icache_pkg::OP_INDEX_INVALID, 32'h0000_0122);  // way 2 holds tag 7
        add_fetch(32'h0006_0124, 1'b0, 1'b0);
        add_fetch(32'h0008_0128, 1'b0, 1'b0);
        add_fetch(32'h0009_012c, 1'b0, 1'b0);
        add_fetch(32'h0007_0130, 1'b0, 1'b1);
        add_op(icache_pkg::OP_INDEX_STORE_TAG, 32'h0000_0121);  // way 1 holds tag 8
        add_fetch(32'h0007_0134, 1'b0, 1'b0);
        add_fetch(32'h0009_0138, 1'b0, 1'b0);
        add_fetch(32'h0008_013c, 1'b0, 1'b1);
        add_fetch(32'h0006_0120, 1'b0, 1'b1);  // set full again
        add_op(icache_pkg::OP_HIT_INVALID, 32'h0000_0120);
        for (int t = 6; t <= 9; t++) begin
            add_fetch((32'(t) << 16) | 32'h0000_0124, 1'b0, 1'b1);
        end
        add_fetch(32'h0006_0128, 1'b0, 1'b0);
    endtask

    // tree update for an access to way w
    function automatic logic [2:0] lru_after(input logic [2:0] b, input logic [1:0] w);
        logic [2:0] n;
        n    = b;
        n[0] = ~w[1];
        if (w[1] == 1'b0) begin
            n[1] = ~w[0];
        end else begin
            n[2] = ~w[0];
        end
        return n;
    endfunction

    // 1 when the fetch has to go to the bus
    function automatic logic model_fetch(input logic [31:0] addr, input logic nc);
        logic [6:0]  idx;
        logic [19:0] tag;
        logic [1:0]  way;
        logic        hit;
        idx = addr[11:5];
        tag = addr[31:12];
        hit = 1'b0;
        way = 2'd0;
        if (nc) begin
            return 1'b1;  // tags and lru untouched
        end
        for (int w = 0; w < 4; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        if (!hit) begin
            way = {ref_lru[idx][0], ref_lru[idx][0] ? ref_lru[idx][2] : ref_lru[idx][1]};
            ref_tag[idx][way]   = tag;
            ref_valid[idx][way] = 1'b1;
        end
        ref_lru[idx] = lru_after(ref_lru[idx], way);
        return !hit;
    endfunction

    function automatic void model_op(input icache_pkg::cache_op_e op,
                                     input logic [31:0] addr);
        for (int w = 0; w < 4; w++) begin
            if (op == icache_pkg::OP_HIT_INVALID || addr[1:0] == 2'(w)) begin
                ref_valid[addr[11:5]][w] = 1'b0;
            end
        end
    endfunction

    task automatic do_fetch(input entry_t e, input logic exp_burst);
        int   bursts_before;
        logic stalled;
        @(negedge clk);
        fetch_en      = 1'b1;
        fetch_addr    = e.addr;
        no_cache      = e.no_cache;
        bursts_before = burst_count;
        #1;
        stalled = stall;
        while (stall) begin  // stays high until the DONE cycle
            @(negedge clk);
            #1;
        end
        check_value("stall_at_fetch", stalled, exp_burst);
        check_value("inst_rdata", inst_rdata, e.addr ^ DATA_KEY);
        check_value("burst_count", burst_count - bursts_before, exp_burst);
        if (exp_burst) begin
            check_value("araddr", last_araddr, e.no_cache ? e.addr : {e.addr[31:5], 5'b0});
            check_value("arlen", last_arlen, e.no_cache ? 32'd0 : 32'd7);
        end
    endtask

    task automatic do_cache_op(input entry_t e);
        int bursts_before;
        @(negedge clk);
        fetch_en      = 1'b0;
        cache_op      = e.op;
        cache_op_addr = e.addr;
        bursts_before = burst_count;
        @(negedge clk);
        cache_op = icache_pkg::OP_NONE;
        check_value("burst_count", burst_count - bursts_before, 0);
    endtask

    initial begin
        rst           = 1'b1;
        fetch_en      = 1'b0;
        fetch_addr    = '0;
        no_cache      = 1'b0;
        cache_op      = icache_pkg::OP_NONE;
        cache_op_addr = '0;
        build_table();
        for (int s = 0; s < icache_pkg::SET_NUM; s++) begin
            ref_lru[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        #1;
        check_value("arvalid", arvalid, 0);
        check_value("rready", rready, 0);
        check_value("stall", stall, 0);
        foreach (table_q[i]) begin
            if (table_q[i].op == icache_pkg::OP_NONE) begin
                predicted = model_fetch(table_q[i].addr, table_q[i].no_cache);
                check_value("table_burst", table_q[i].burst, predicted);
                expected_bursts += predicted;
                do_fetch(table_q[i], predicted);
            end else begin
                model_op(table_q[i].op, table_q[i].addr);
                do_cache_op(table_q[i]);
            end
        end
        @(negedge clk);
        fetch_en = 1'b0;
        repeat (2) @(negedge clk);
        check_value("total_bursts", burst_count, expected_bursts);
        $display("NO ERRORS");
        $finish;
    end

    // limit scales with the table length
    initial begin
        #1;
        repeat (RESET_CYCLES + table_q.size() * CYCLES_PER_ENTRY) @(posedge clk);
        $display("timeout: the test table did not complete in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- icache.f
icache_pkg.sv
icache_way.sv
icache_ctrl.sv
icache_select.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv
